// File: hdl/conv_geom_pkg.sv
package conv_geom_pkg;

  ////////////////////
  // Input frame
  localparam int IMAGE_WIDTH    = 8;
  localparam int IMAGE_HEIGHT   = 8;
  localparam int CHANNEL_NUM_IN = 2;

  ////////////////////
  // Kernel and dilation
  localparam int KERNEL = 3;
  localparam int RATE   = 2;
  // Reach of one dilated window, in pixels
  localparam int SPAN   = RATE * (KERNEL - 1);
  localparam int TAPS   = KERNEL * KERNEL;

  ////////////////////
  // Valid-mode output and buffer depths
  localparam int OUT_WIDTH    = IMAGE_WIDTH - SPAN;
  localparam int OUT_HEIGHT   = IMAGE_HEIGHT - SPAN;
  localparam int OUT_SIZE     = OUT_WIDTH * OUT_HEIGHT;
  // Oldest tap sits SPAN rows and SPAN columns back
  localparam int WINDOW_DEPTH = SPAN * IMAGE_WIDTH + SPAN + 1;
  localparam int WEIGHT_COUNT = TAPS * CHANNEL_NUM_IN;

endpackage

// File: hdl/fixed_point_pkg.sv
package fixed_point_pkg;

  ////////////////////
  // Pixel and weight words, signed Q8.8
  localparam int DATA_WIDTH = 16;
  localparam int FRAC_BITS  = 8;

  ////////////////////
  // Full product of two words
  localparam int PROD_WIDTH = 2 * DATA_WIDTH;
  // Room for 18 products plus sign growth
  localparam int ACC_WIDTH  = 40;

  // Saturation limits of a Q8.8 word
  localparam logic signed [DATA_WIDTH-1:0] DATA_MAX = {1'b0, {(DATA_WIDTH - 1){1'b1}}};
  localparam logic signed [DATA_WIDTH-1:0] DATA_MIN = {1'b1, {(DATA_WIDTH - 1){1'b0}}};

endpackage

// File: hdl/conv_weight_buffer.sv
`timescale 1ns/10ps

module conv_weight_buffer
  import fixed_point_pkg::*;
  import conv_geom_pkg::*;
(
  input  logic                             clk,
  input  logic                             reset,
  input  logic                             valid_weight_in,
  input  logic [DATA_WIDTH-1:0]            weight_in,
  input  logic                             tap_valid,
  output logic [TAPS-1:0][DATA_WIDTH-1:0]  weights
);

  // All channels, channel-major, taps row-major
  logic [DATA_WIDTH-1:0] weight_mem [WEIGHT_COUNT];

  logic [$clog2(WEIGHT_COUNT)-1:0]   wr_ptr;
  logic [$clog2(OUT_SIZE)-1:0]       tap_cnt;
  logic [$clog2(CHANNEL_NUM_IN)-1:0] chan_sel;

  ////////////////////
  // Serial weight load
  always_ff @(posedge clk) begin
    if (valid_weight_in) begin
      weight_mem[wr_ptr] <= weight_in;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
    end else if (valid_weight_in) begin
      // Wrap so the next image reloads from entry 0
      wr_ptr <= (wr_ptr == WEIGHT_COUNT - 1) ? '0 : wr_ptr + 1'b1;
    end
  end

  ////////////////////
  // Channel select follows the window count
  always_ff @(posedge clk) begin
    if (reset) begin
      tap_cnt  <= '0;
      chan_sel <= '0;
    end else if (tap_valid) begin
      if (tap_cnt == OUT_SIZE - 1) begin
        tap_cnt  <= '0;
        // Last window of the frame, move on to next channel
        chan_sel <= (chan_sel == CHANNEL_NUM_IN - 1) ? '0 : chan_sel + 1'b1;
      end else begin
        tap_cnt <= tap_cnt + 1'b1;
      end
    end
  end

  // Nine weights of the channel in flight
  always_comb begin
    for (int t = 0; t < TAPS; t++) begin
      weights[t] = weight_mem[chan_sel * TAPS + t];
    end
  end

  // Weights must not change under a frame that is half convolved
  a_no_load_mid_frame : assert property (
    @(posedge clk) disable iff (reset) valid_weight_in |-> tap_cnt == '0
  );

endmodule

// File: hdl/dilated_window.sv
`timescale 1ns/10ps

module dilated_window
  import fixed_point_pkg::*;
  import conv_geom_pkg::*;
(
  input  logic                             clk,
  input  logic                             reset,
  input  logic                             valid_in,
  input  logic [DATA_WIDTH-1:0]            pxl_in,
  output logic                             tap_valid,
  output logic [TAPS-1:0][DATA_WIDTH-1:0]  taps
);

  // Entry 0 is the newest pixel
  logic [DATA_WIDTH-1:0] delay_line [WINDOW_DEPTH];

  // Position of the incoming pixel in its frame
  logic [$clog2(IMAGE_WIDTH)-1:0]  col;
  logic [$clog2(IMAGE_HEIGHT)-1:0] row;

  ////////////////////
  // Pixel delay line
  always_ff @(posedge clk) begin
    if (valid_in) begin
      delay_line[0] <= pxl_in;
      for (int i = 1; i < WINDOW_DEPTH; i++) begin
        delay_line[i] <= delay_line[i - 1];
      end
    end
  end

  ////////////////////
  // Raster counters
  always_ff @(posedge clk) begin
    if (reset) begin
      col <= '0;
      row <= '0;
    end else if (valid_in) begin
      if (col == IMAGE_WIDTH - 1) begin
        col <= '0;
        // End of frame wraps back to the top row
        row <= (row == IMAGE_HEIGHT - 1) ? '0 : row + 1'b1;
      end else begin
        col <= col + 1'b1;
      end
    end
  end

  // Window complete once the pixel is SPAN rows and columns in
  always_ff @(posedge clk) begin
    if (reset) begin
      tap_valid <= 1'b0;
    end else begin
      tap_valid <= valid_in && (col >= SPAN) && (row >= SPAN);
    end
  end

  ////////////////////
  // Dilated taps
  // Tap r,c lies (2-r)*RATE rows and (2-c)*RATE columns back
  // Tap 0 is the top-left and oldest
  always_comb begin
    for (int r = 0; r < KERNEL; r++) begin
      for (int c = 0; c < KERNEL; c++) begin
        taps[r * KERNEL + c] =
          delay_line[(KERNEL - 1 - r) * RATE * IMAGE_WIDTH + (KERNEL - 1 - c) * RATE];
      end
    end
  end

endmodule

// File: hdl/conv_mac_3x3.sv
`timescale 1ns/10ps

module conv_mac_3x3
  import fixed_point_pkg::*;
  import conv_geom_pkg::*;
(
  input  logic                             clk,
  input  logic                             reset,
  input  logic                             tap_valid,
  input  logic [TAPS-1:0][DATA_WIDTH-1:0]  taps,
  input  logic [TAPS-1:0][DATA_WIDTH-1:0]  weights,
  output logic                             sum_valid,
  output logic signed [ACC_WIDTH-1:0]      sum
);

  logic signed [PROD_WIDTH-1:0] prod [TAPS];
  logic signed [ACC_WIDTH-1:0]  tree_sum;
  logic                         prod_valid;

  ////////////////////
  // Stage one, full-width products
  always_ff @(posedge clk) begin
    for (int t = 0; t < TAPS; t++) begin
      prod[t] <= $signed(taps[t]) * $signed(weights[t]);
    end
  end

  // Sign-extended sum of the nine products
  always_comb begin
    tree_sum = '0;
    for (int t = 0; t < TAPS; t++) begin
      tree_sum = tree_sum + ACC_WIDTH'(prod[t]);
    end
  end

  ////////////////////
  // Stage two
  always_ff @(posedge clk) begin
    sum <= tree_sum;
  end

  // Strobe follows the data through both stages
  always_ff @(posedge clk) begin
    if (reset) begin
      prod_valid <= 1'b0;
      sum_valid  <= 1'b0;
    end else begin
      prod_valid <= tap_valid;
      sum_valid  <= prod_valid;
    end
  end

endmodule

// File: hdl/channel_accumulator.sv
`timescale 1ns/10ps

module channel_accumulator
  import fixed_point_pkg::*;
  import conv_geom_pkg::*;
(
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         sum_valid,
  input  logic signed [ACC_WIDTH-1:0]  sum,
  output logic                         result_valid,
  output logic [DATA_WIDTH-1:0]        result
);

  // Running partial sum per output position
  logic signed [ACC_WIDTH-1:0] psum_mem [OUT_SIZE];

  logic [$clog2(OUT_SIZE)-1:0]       pos_cnt;
  logic [$clog2(CHANNEL_NUM_IN)-1:0] chan_cnt;
  logic signed [ACC_WIDTH-1:0]       total;
  logic signed [ACC_WIDTH-1:0]       scaled;
  logic                              last_chan;

  assign last_chan = (chan_cnt == CHANNEL_NUM_IN - 1);
  // Channel 0 starts a fresh sum
  assign total     = (chan_cnt == '0) ? sum : psum_mem[pos_cnt] + sum;
  // Back to Q8.8, floor
  assign scaled    = total >>> FRAC_BITS;

  ////////////////////
  // Partial sum memory
  always_ff @(posedge clk) begin
    if (sum_valid && !last_chan) begin
      psum_mem[pos_cnt] <= total;
    end
  end

  ////////////////////
  // Scale and saturate on the last channel
  always_ff @(posedge clk) begin
    if (sum_valid && last_chan) begin
      if (scaled > DATA_MAX) begin
        result <= DATA_MAX;
      end else if (scaled < DATA_MIN) begin
        result <= DATA_MIN;
      end else begin
        result <= scaled[DATA_WIDTH-1:0];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pos_cnt      <= '0;
      chan_cnt     <= '0;
      result_valid <= 1'b0;
    end else begin
      result_valid <= sum_valid && last_chan;
      if (sum_valid) begin
        if (pos_cnt == OUT_SIZE - 1) begin
          pos_cnt  <= '0;
          chan_cnt <= last_chan ? '0 : chan_cnt + 1'b1;
        end else begin
          pos_cnt <= pos_cnt + 1'b1;
        end
      end
    end
  end

endmodule

// File: hdl/output_align_fifo.sv
`timescale 1ns/10ps

module output_align_fifo
  import fixed_point_pkg::*;
  import conv_geom_pkg::*;
(
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   wr_en,
  input  logic [DATA_WIDTH-1:0]  din,
  output logic [DATA_WIDTH-1:0]  dout,
  output logic                   valid_out
);

  logic [DATA_WIDTH-1:0] mem [OUT_SIZE];

  logic [$clog2(OUT_SIZE)-1:0]   wr_ptr;
  logic [$clog2(OUT_SIZE)-1:0]   rd_ptr;
  logic [$clog2(OUT_SIZE + 1)-1:0] count;
  logic                          full;
  logic                          empty;
  logic                          read_en;
  logic                          rd;

  assign full  = (count == OUT_SIZE);
  assign empty = (count == '0);
  assign rd    = read_en && !empty;

  ////////////////////
  // Storage and registered read port
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= din;
    end
    if (rd) begin
      dout <= mem[rd_ptr];
    end
  end

  ////////////////////
  // Pointers and fill level
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      // Depth is a power of two, pointers wrap by themselves
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({wr_en, rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Hold the first frame until full, then stream for good
  always_ff @(posedge clk) begin
    if (reset) begin
      read_en   <= 1'b0;
      valid_out <= 1'b0;
    end else begin
      if (full) begin
        read_en <= 1'b1;
      end
      valid_out <= rd;
    end
  end

  // Overflow would drop a result of the next image
  a_no_overflow : assert property (
    @(posedge clk) disable iff (reset) (wr_en && full) |-> rd
  );

endmodule

// File: hdl/cnn_conv_dilated_3x3.sv
`timescale 1ns/10ps

module cnn_conv_dilated_3x3
  import fixed_point_pkg::*;
  import conv_geom_pkg::*;
(
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   valid_in,
  input  logic [DATA_WIDTH-1:0]  pxl_in,
  input  logic                   valid_weight_in,
  input  logic [DATA_WIDTH-1:0]  weight_in,
  output logic [DATA_WIDTH-1:0]  pxl_out,
  output logic                   valid_out
);

  ////////////////////
  // Stage wiring
  logic                            tap_valid;
  logic [TAPS-1:0][DATA_WIDTH-1:0] taps;
  logic [TAPS-1:0][DATA_WIDTH-1:0] weights;
  logic                            sum_valid;
  logic signed [ACC_WIDTH-1:0]     sum;
  logic                            result_valid;
  logic [DATA_WIDTH-1:0]           result;

  // Kernel weights per channel
  conv_weight_buffer u_weights (
    .clk             (clk),
    .reset           (reset),
    .valid_weight_in (valid_weight_in),
    .weight_in       (weight_in),
    .tap_valid       (tap_valid),
    .weights         (weights)
  );

  // Rate-2 window over the raster stream
  dilated_window u_window (
    .clk       (clk),
    .reset     (reset),
    .valid_in  (valid_in),
    .pxl_in    (pxl_in),
    .tap_valid (tap_valid),
    .taps      (taps)
  );

  conv_mac_3x3 u_mac (
    .clk       (clk),
    .reset     (reset),
    .tap_valid (tap_valid),
    .taps      (taps),
    .weights   (weights),
    .sum_valid (sum_valid),
    .sum       (sum)
  );

  // Sum over input channels
  channel_accumulator u_acc (
    .clk          (clk),
    .reset        (reset),
    .sum_valid    (sum_valid),
    .sum          (sum),
    .result_valid (result_valid),
    .result       (result)
  );

  output_align_fifo u_fifo (
    .clk       (clk),
    .reset     (reset),
    .wr_en     (result_valid),
    .din       (result),
    .dout      (pxl_out),
    .valid_out (valid_out)
  );

endmodule

// File: verification/conv_ref_model.svh
`ifndef CONV_REF_MODEL_SVH
`define CONV_REF_MODEL_SVH

////////////////////
// Stimulus patterns
typedef enum logic [2:0] {
  IMG_RAMP,
  IMG_CORNER,
  IMG_RANDOM,
  IMG_LARGE_POS,
  IMG_LARGE_NEG
} img_pat_e;

typedef enum logic [2:0] {
  WGT_CENTER,
  WGT_CORNER,
  WGT_RANDOM,
  WGT_MAX
} wgt_pat_e;

// 1.0 in Q8.8
localparam int     UNIT   = 1 << FRAC_BITS;
localparam longint SAT_HI = (longint'(1) <<< (DATA_WIDTH - 1)) - 1;
localparam longint SAT_LO = -(longint'(1) <<< (DATA_WIDTH - 1));

// Current image and kernel, channel-major
logic signed [DATA_WIDTH-1:0] img_data [CHANNEL_NUM_IN][IMAGE_HEIGHT][IMAGE_WIDTH];
logic signed [DATA_WIDTH-1:0] wgt_data [CHANNEL_NUM_IN][TAPS];

task automatic build_image(img_pat_e pat);
  for (int ch = 0; ch < CHANNEL_NUM_IN; ch++) begin
    for (int r = 0; r < IMAGE_HEIGHT; r++) begin
      for (int c = 0; c < IMAGE_WIDTH; c++) begin
        case (pat)
          // Distinct value per position and channel
          IMG_RAMP:
            img_data[ch][r][c] = DATA_WIDTH'(((ch * IMAGE_HEIGHT + r) * IMAGE_WIDTH + c) * 32);
          IMG_CORNER:
            img_data[ch][r][c] = (r == 0 && c == 0) ? DATA_WIDTH'(UNIT) : '0;
          // Roughly +-8.0
          IMG_RANDOM:
            img_data[ch][r][c] = DATA_WIDTH'(int'($urandom % 4096) - 2048);
          IMG_LARGE_POS:
            img_data[ch][r][c] = 16'sh7fff;
          default:
            img_data[ch][r][c] = 16'sh8000;
        endcase
      end
    end
  end
endtask

task automatic build_weights(wgt_pat_e pat);
  for (int ch = 0; ch < CHANNEL_NUM_IN; ch++) begin
    for (int t = 0; t < TAPS; t++) begin
      case (pat)
        // Middle tap of the 3x3 kernel
        WGT_CENTER: wgt_data[ch][t] = (t == TAPS / 2) ? DATA_WIDTH'(UNIT) : '0;
        WGT_CORNER: wgt_data[ch][t] = (t == 0) ? DATA_WIDTH'(UNIT) : '0;
        // Roughly +-0.5
        WGT_RANDOM: wgt_data[ch][t] = DATA_WIDTH'(int'($urandom % 256) - 128);
        default:    wgt_data[ch][t] = 16'sh7fff;
      endcase
    end
  end
endtask

// Expected output at valid-mode position r, c
function automatic int ref_output(int r, int c);
  longint acc;
  acc = 0;
  for (int ch = 0; ch < CHANNEL_NUM_IN; ch++) begin
    for (int kr = 0; kr < KERNEL; kr++) begin
      for (int kc = 0; kc < KERNEL; kc++) begin
        acc = acc + longint'(img_data[ch][r + RATE * kr][c + RATE * kc])
                  * longint'(wgt_data[ch][kr * KERNEL + kc]);
      end
    end
  end
  // Floor back to Q8.8
  acc = acc >>> FRAC_BITS;
  if (acc > SAT_HI) begin
    return int'(SAT_HI);
  end else if (acc < SAT_LO) begin
    return int'(SAT_LO);
  end else begin
    return int'(acc);
  end
endfunction

`endif

// File: verification/tb_cnn_conv_dilated_3x3.sv
`timescale 1ns/10ps

module tb_cnn_conv_dilated_3x3
  import fixed_point_pkg::*;
  import conv_geom_pkg::*;
();

  logic                  clk;
  logic                  reset;
  logic                  valid_in;
  logic [DATA_WIDTH-1:0] pxl_in;
  logic                  valid_weight_in;
  logic [DATA_WIDTH-1:0] weight_in;
  logic [DATA_WIDTH-1:0] pxl_out;
  logic                  valid_out;

  `include "conv_ref_model.svh"

  ////////////////////
  // Stimulus table
  typedef struct packed {
    img_pat_e   img;
    wgt_pat_e   wgt;
    logic [7:0] gap_pct;
  } stim_row_t;

  localparam int NUM_ROWS = 9;
  localparam stim_row_t STIM_TABLE [NUM_ROWS] = '{
    '{IMG_RAMP,      WGT_CENTER, 8'd0},
    '{IMG_RAMP,      WGT_CORNER, 8'd0},
    '{IMG_CORNER,    WGT_CORNER, 8'd0},
    '{IMG_RANDOM,    WGT_RANDOM, 8'd0},
    '{IMG_RANDOM,    WGT_RANDOM, 8'd30},
    '{IMG_LARGE_POS, WGT_MAX,    8'd0},
    '{IMG_LARGE_NEG, WGT_MAX,    8'd20},
    '{IMG_RAMP,      WGT_RANDOM, 8'd40},
    '{IMG_RAMP,      WGT_CENTER, 8'd25}
  };

  // Run budget
  localparam int TIMEOUT_CYCLES = 500 * NUM_ROWS + 200;
  localparam int DRAIN_CYCLES   = 40;

  logic signed [DATA_WIDTH-1:0] out_q [$];
  logic                         pixels_done;
  int                           cycle_count = 0;

  cnn_conv_dilated_3x3 dut (
    .clk             (clk),
    .reset           (reset),
    .valid_in        (valid_in),
    .pxl_in          (pxl_in),
    .valid_weight_in (valid_weight_in),
    .weight_in       (weight_in),
    .pxl_out         (pxl_out),
    .valid_out       (valid_out)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic abort_run(string msg);
    $display("%s", msg);
    $display("Test failures found");
    $fatal(1);
  endtask

  task automatic check_equal(int expected, int actual, string what);
    if (expected != actual) begin
      abort_run($sformatf("ERR %0t: %s expected %0d got %0d", $time, what, expected, actual));
    end
  endtask

  // Hard stop on a hung run
  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      abort_run($sformatf("Timeout, run went past %0d cycles", TIMEOUT_CYCLES));
    end
  end

  ////////////////////
  // Advance to a falling edge and sample outputs before new inputs go out
  task automatic tick();
    @(negedge clk);
    if (valid_out) begin
      if (reset) begin
        abort_run("valid_out was high while reset was applied");
      end else if (!pixels_done) begin
        abort_run("valid_out rose before the whole image had been sent");
      end else begin
        out_q.push_back(pxl_out);
      end
    end
  endtask

  // Eight reset cycles clear the FIFO and re-arm read start-up
  task automatic apply_reset();
    tick();
    reset           = 1'b1;
    valid_in        = 1'b0;
    valid_weight_in = 1'b0;
    repeat (8) tick();
    reset = 1'b0;
  endtask

  // Kernel then both channel frames
  task automatic send_image(int gap);
    // Kernel load with channel 0 first
    for (int ch = 0; ch < CHANNEL_NUM_IN; ch++) begin
      for (int t = 0; t < TAPS; t++) begin
        tick();
        valid_weight_in = 1'b1;
        weight_in       = wgt_data[ch][t];
      end
    end
    tick();
    valid_weight_in = 1'b0;
    weight_in       = '0;
    // Channel-major raster with random idle cycles
    for (int ch = 0; ch < CHANNEL_NUM_IN; ch++) begin
      for (int r = 0; r < IMAGE_HEIGHT; r++) begin
        for (int c = 0; c < IMAGE_WIDTH; c++) begin
          while (($urandom % 100) < gap) begin
            tick();
            valid_in = 1'b0;
          end
          tick();
          valid_in = 1'b1;
          pxl_in   = img_data[ch][r][c];
        end
      end
    end
    tick();
    valid_in    = 1'b0;
    pixels_done = 1'b1;
  endtask

  task automatic run_row(int idx);
    stim_row_t entry;
    entry = STIM_TABLE[idx];
    build_image(entry.img);
    build_weights(entry.wgt);
    out_q.delete();
    pixels_done = 1'b0;
    // Empty FIFO and re-armed start-up for every row
    apply_reset();
    send_image(int'(entry.gap_pct));
    while (out_q.size() < OUT_SIZE) begin
      tick();
    end
    // Anything extra shows up here
    repeat (DRAIN_CYCLES) tick();
    check_equal(OUT_SIZE, out_q.size(), $sformatf("row %0d output count", idx));
    for (int i = 0; i < OUT_SIZE; i++) begin
      check_equal(ref_output(i / OUT_WIDTH, i % OUT_WIDTH), int'(out_q[i]),
                  $sformatf("row %0d output %0d", idx, i));
    end
  endtask

  // Reset lands while the FIFO is still streaming
  task automatic reset_mid_burst();
    out_q.delete();
    pixels_done = 1'b0;
    apply_reset();
    send_image(0);
    while (out_q.size() == 0) begin
      tick();
    end
    // valid_out must drop on the first reset edge
    apply_reset();
    // Nothing may come out of the cleared FIFO
    pixels_done = 1'b0;
    repeat (DRAIN_CYCLES) tick();
  endtask

  ////////////////////
  // Main sequence
  initial begin
    void'($urandom(32'h9f62));
    reset           = 1'b1;
    valid_in        = 1'b0;
    pxl_in          = '0;
    valid_weight_in = 1'b0;
    weight_in       = '0;
    pixels_done     = 1'b0;
    for (int i = 0; i < NUM_ROWS; i++) begin
      run_row(i);
    end
    reset_mid_burst();
    $display("All tests passed!");
    $finish;
  end

endmodule

// File: cnn_conv_dilated_3x3.f
+incdir+verification
hdl/conv_geom_pkg.sv
hdl/fixed_point_pkg.sv
hdl/conv_weight_buffer.sv
hdl/dilated_window.sv
hdl/conv_mac_3x3.sv
hdl/channel_accumulator.sv
hdl/output_align_fifo.sv
hdl/cnn_conv_dilated_3x3.sv
verification/tb_cnn_conv_dilated_3x3.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f cnn_conv_dilated_3x3.f --top-module tb_cnn_conv_dilated_3x3 -o sim_tb

obj_dir/sim_tb 2>&1 | tee sim.log

if grep -q "All tests passed!" sim.log; then
  echo "Simulation PASSED"
else
  echo "Simulation FAILED"
  exit 1
fi
